//--- common/pipePkg.sv
package pipePkg;

    ////////////////////////////////////////
    // pipeline register fields
    ////////////////////////////////////////

    // r0 reads as zero and is never a hazard source.
    typedef logic [4:0] regAddrT;

    // forwarding select for one operand.
    typedef logic [1:0] fwdSelT;

    localparam fwdSelT fwdRegFile = 2'd0;
    localparam fwdSelT fwdFromW   = 2'd1;
    localparam fwdSelT fwdFromM   = 2'd2;

    ////////////////////////////////////////
    // APB register map
    ////////////////////////////////////////

    typedef logic [7:0]  apbAddrT;
    typedef logic [31:0] apbDataT;

    // stall counters, one per cause.
    localparam apbAddrT addrLoadUse = 8'h00;
    localparam apbAddrT addrBranch  = 8'h04;
    localparam apbAddrT addrMulti   = 8'h08;
    localparam apbAddrT addrWait    = 8'h0C;

    // any write here zeroes all counters.
    localparam apbAddrT addrClear   = 8'h10;

    localparam int numStallCnt = 4;

endpackage

//--- design/hazard/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  pipePkg::regAddrT ra1,
    input  pipePkg::regAddrT ra2,
    input  pipePkg::regAddrT ra1E,
    input  pipePkg::regAddrT ra2E,
    input  pipePkg::regAddrT dstE,
    input  pipePkg::regAddrT dstM,
    input  pipePkg::regAddrT dstW,
    input  logic             wrE,
    input  logic             wrM,
    input  logic             wrW,
    input  logic             loadE,
    input  logic             loadM,
    input  logic             branchD,
    input  logic             branchCmpD,
    input  logic             multiD,
    input  logic             iWait,
    input  logic             dWait,
    input  logic             eWait,
    output logic             stallF,
    output logic             stallD,
    output logic             flushD,
    output logic             stallE,
    output logic             flushE,
    output logic             stallM,
    output logic             flushM,
    output logic             loadUseStall,
    output logic             branchStall,
    output logic             multiStall,
    output logic             waitStall,
    output pipePkg::fwdSelT  fwdAD,
    output pipePkg::fwdSelT  fwdBD,
    output pipePkg::fwdSelT  fwdAE,
    output pipePkg::fwdSelT  fwdBE
);
    import pipePkg::*;

    logic eHit;
    logic mLoadHit;
    logic mWrHit;
    logic loadUse;
    logic branchHaz;
    logic multiHaz;

    // newest writer wins, r0 never forwards.
    function automatic fwdSelT pickFwd(input regAddrT src, input logic mWr,
                                       input regAddrT mDst, input logic wWr,
                                       input regAddrT wDst);
        if (src == '0) begin
            return fwdRegFile;
        end else if (mWr && mDst == src) begin
            return fwdFromM;
        end else if (wWr && wDst == src) begin
            return fwdFromW;
        end
        return fwdRegFile;
    endfunction

    ////////////////////////////////////////
    // hazard terms
    ////////////////////////////////////////

    assign eHit     = wrE && dstE != '0 && (dstE == ra1 || dstE == ra2);
    assign mLoadHit = loadM && dstM != '0 && (dstM == ra1 || dstM == ra2);
    assign mWrHit   = wrM && ((ra1 != '0 && ra1 == dstM) || (ra2 != '0 && ra2 == dstM));
    assign loadUse  = loadE && dstE != '0 && (dstE == ra1 || dstE == ra2);

    // compare branch needs both operands in decode.
    assign branchHaz = branchCmpD && (eHit || mLoadHit);
    assign multiHaz  = multiD && (eHit || mLoadHit || mWrHit);

    assign waitStall = iWait || dWait || eWait;

    always_comb begin
        stallF       = 1'b0;
        stallD       = 1'b0;
        flushD       = 1'b0;
        stallE       = 1'b0;
        flushE       = 1'b0;
        stallM       = 1'b0;
        flushM       = 1'b0;
        loadUseStall = 1'b0;
        branchStall  = 1'b0;
        multiStall   = 1'b0;
        if (eWait) begin
            stallF = 1'b1;
            stallD = 1'b1;
            stallE = 1'b1;
            // M keeps its op only when the data side is busy too.
            stallM = dWait;
            flushM = !dWait;
        end else if (dWait) begin
            stallF = 1'b1;
            stallD = 1'b1;
            stallE = 1'b1;
            stallM = 1'b1;
        end else if (iWait) begin
            stallF      = 1'b1;
            flushD      = 1'b1;
            branchStall = branchHaz;
            multiStall  = multiHaz;
            // keep the branch in decode until fetch returns.
            if (branchD || branchHaz || multiHaz) begin
                flushD = 1'b0;
                stallD = 1'b1;
                flushE = 1'b1;
            end
        end else begin
            loadUseStall = loadUse;
            branchStall  = branchHaz;
            multiStall   = multiHaz;
            stallD       = loadUse || branchHaz || multiHaz;
            stallF       = stallD;
            flushE       = stallD;
            flushD       = branchD && !branchHaz;
        end
        stallFlushD: assert (!(stallD && flushD))
            else $error("decode stalled and flushed together");
    end

    ////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////

    always_comb begin
        fwdAD = pickFwd(ra1, wrM, dstM, wrW, dstW);
        fwdBD = pickFwd(ra2, wrM, dstM, wrW, dstW);
        // execute operands are frozen while E waits.
        fwdAE = eWait ? fwdRegFile : pickFwd(ra1E, wrM, dstM, wrW, dstW);
        fwdBE = eWait ? fwdRegFile : pickFwd(ra2E, wrM, dstM, wrW, dstW);
        fwdLegal: assert (fwdAD != 2'd3 && fwdBD != 2'd3 && fwdAE != 2'd3 && fwdBE != 2'd3)
            else $error("illegal forwarding select");
    end

endmodule

//--- design/hazard/stageTracker.sv
`timescale 1ns/100ps

module stageTracker (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::regAddrT dstD,
    input  pipePkg::regAddrT ra1,
    input  pipePkg::regAddrT ra2,
    input  logic             wrD,
    input  logic             loadD,
    input  logic             stallE,
    input  logic             flushE,
    input  logic             stallM,
    input  logic             flushM,
    output pipePkg::regAddrT dstE,
    output pipePkg::regAddrT dstM,
    output pipePkg::regAddrT dstW,
    output pipePkg::regAddrT ra1E,
    output pipePkg::regAddrT ra2E,
    output logic             wrE,
    output logic             wrM,
    output logic             wrW,
    output logic             loadE,
    output logic             loadM
);

    // execute stage.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dstE  <= '0;
            ra1E  <= '0;
            ra2E  <= '0;
            wrE   <= 1'b0;
            loadE <= 1'b0;
        end else if (!stallE) begin
            dstE  <= flushE ? '0 : dstD;
            ra1E  <= flushE ? '0 : ra1;
            ra2E  <= flushE ? '0 : ra2;
            wrE   <= !flushE && wrD;
            loadE <= !flushE && loadD;
        end
    end

    // memory stage.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dstM  <= '0;
            wrM   <= 1'b0;
            loadM <= 1'b0;
        end else if (!stallM) begin
            dstM  <= flushM ? '0 : dstE;
            wrM   <= !flushM && wrE;
            loadM <= !flushM && loadE;
        end
    end

    // writeback gets a bubble while M holds.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dstW <= '0;
            wrW  <= 1'b0;
        end else begin
            dstW <= stallM ? '0 : dstM;
            wrW  <= !stallM && wrM;
        end
    end

    bubbleE: assert property (@(posedge clk) disable iff (!rstN)
        (flushE && !stallE) |=> (!wrE && !loadE));
    bubbleM: assert property (@(posedge clk) disable iff (!rstN)
        (flushM && !stallM) |=> (!wrM && !loadM));
    bubbleW: assert property (@(posedge clk) disable iff (!rstN)
        stallM |=> !wrW);

endmodule

//--- design/perfRegs.sv
`timescale 1ns/100ps

module perfRegs (
    input  logic             clk,
    input  logic             rstN,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  pipePkg::apbAddrT paddr,
    input  pipePkg::apbDataT pwdata,
    input  logic             loadUseStall,
    input  logic             branchStall,
    input  logic             multiStall,
    input  logic             waitStall,
    output pipePkg::apbDataT prdata,
    output logic             pslverr
);
    import pipePkg::*;

    logic [numStallCnt-1:0] pulse;
    apbDataT                cnt [numStallCnt];
    apbDataT                rdMux;
    logic                   mapped;
    logic                   access;
    logic                   clearHit;

    // order follows the address map.
    assign pulse    = {waitStall, multiStall, branchStall, loadUseStall};
    assign access   = psel && penable;
    assign clearHit = access && pwrite && paddr == addrClear;

    ////////////////////////////////////////
    // stall counters
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numStallCnt; i++) begin
                cnt[i] <= '0;
            end
        end else if (clearHit) begin
            for (int i = 0; i < numStallCnt; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            // saturate, never wrap.
            for (int i = 0; i < numStallCnt; i++) begin
                if (pulse[i] && cnt[i] != '1) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // read decode
    ////////////////////////////////////////

    always_comb begin
        rdMux  = '0;
        mapped = 1'b1;
        case (paddr)
            addrLoadUse: rdMux = cnt[0];
            addrBranch:  rdMux = cnt[1];
            addrMulti:   rdMux = cnt[2];
            addrWait:    rdMux = cnt[3];
            addrClear:   rdMux = '0;
            default:     mapped = 1'b0;
        endcase
    end

    // zero wait states, data and error in the access cycle.
    assign prdata  = (access && !pwrite) ? rdMux : '0;
    assign pslverr = access && !mapped;

    apbEnable: assert property (@(posedge clk) disable iff (!rstN)
        penable |-> psel);
    apbWdata: assert property (@(posedge clk) disable iff (!rstN)
        (access && pwrite) |-> !$isunknown(pwdata));

endmodule

//--- design/pipeCtrl.sv
`timescale 1ns/100ps

module pipeCtrl (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::regAddrT ra1,
    input  pipePkg::regAddrT ra2,
    input  pipePkg::regAddrT dstD,
    input  logic             wrD,
    input  logic             loadD,
    input  logic             multiD,
    input  logic             branchD,
    input  logic             branchCmpD,
    input  logic             iWait,
    input  logic             dWait,
    input  logic             eWait,
    output logic             stallF,
    output logic             stallD,
    output logic             flushD,
    output logic             stallE,
    output logic             flushE,
    output logic             stallM,
    output logic             flushM,
    output pipePkg::fwdSelT  fwdAD,
    output pipePkg::fwdSelT  fwdBD,
    output pipePkg::fwdSelT  fwdAE,
    output pipePkg::fwdSelT  fwdBE,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  pipePkg::apbAddrT paddr,
    input  pipePkg::apbDataT pwdata,
    output pipePkg::apbDataT prdata,
    output logic             pslverr
);
    import pipePkg::*;

    regAddrT dstE;
    regAddrT dstM;
    regAddrT dstW;
    regAddrT ra1E;
    regAddrT ra2E;
    logic    wrE;
    logic    wrM;
    logic    wrW;
    logic    loadE;
    logic    loadM;
    logic    loadUseStall;
    logic    branchStall;
    logic    multiStall;
    logic    waitStall;

    stageTracker stageTracker_i (
        .clk(clk), .rstN(rstN),
        .dstD(dstD), .ra1(ra1), .ra2(ra2), .wrD(wrD), .loadD(loadD),
        .stallE(stallE), .flushE(flushE), .stallM(stallM), .flushM(flushM),
        .dstE(dstE), .dstM(dstM), .dstW(dstW), .ra1E(ra1E), .ra2E(ra2E),
        .wrE(wrE), .wrM(wrM), .wrW(wrW), .loadE(loadE), .loadM(loadM)
    );

    hazardUnit hazardUnit_i (
        .ra1(ra1), .ra2(ra2), .ra1E(ra1E), .ra2E(ra2E),
        .dstE(dstE), .dstM(dstM), .dstW(dstW),
        .wrE(wrE), .wrM(wrM), .wrW(wrW), .loadE(loadE), .loadM(loadM),
        .branchD(branchD), .branchCmpD(branchCmpD), .multiD(multiD),
        .iWait(iWait), .dWait(dWait), .eWait(eWait),
        .stallF(stallF), .stallD(stallD), .flushD(flushD),
        .stallE(stallE), .flushE(flushE), .stallM(stallM), .flushM(flushM),
        .loadUseStall(loadUseStall), .branchStall(branchStall),
        .multiStall(multiStall), .waitStall(waitStall),
        .fwdAD(fwdAD), .fwdBD(fwdBD), .fwdAE(fwdAE), .fwdBE(fwdBE)
    );

    perfRegs perfRegs_i (
        .clk(clk), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .loadUseStall(loadUseStall), .branchStall(branchStall),
        .multiStall(multiStall), .waitStall(waitStall),
        .prdata(prdata), .pslverr(pslverr)
    );

endmodule

//--- sim/pipeCtrlTb.sv
`timescale 1ns/100ps

module pipeCtrlTb;

    // one table row, one clock cycle.
    typedef struct packed {
        logic [4:0] ra1;
        logic [4:0] ra2;
        logic [4:0] dst;
        logic [7:0] ctl;
        logic [6:0] stl;
        logic [7:0] fwd;
        logic [3:0] cause;
    } rowT;

    logic             clk;
    logic             rstN;
    pipePkg::regAddrT ra1;
    pipePkg::regAddrT ra2;
    pipePkg::regAddrT dstD;
    logic             wrD;
    logic             loadD;
    logic             multiD;
    logic             branchD;
    logic             branchCmpD;
    logic             iWait;
    logic             dWait;
    logic             eWait;
    logic             stallF;
    logic             stallD;
    logic             flushD;
    logic             stallE;
    logic             flushE;
    logic             stallM;
    logic             flushM;
    pipePkg::fwdSelT  fwdAD;
    pipePkg::fwdSelT  fwdBD;
    pipePkg::fwdSelT  fwdAE;
    pipePkg::fwdSelT  fwdBE;
    logic             psel;
    logic             penable;
    logic             pwrite;
    pipePkg::apbAddrT paddr;
    pipePkg::apbDataT pwdata;
    pipePkg::apbDataT prdata;
    logic             pslverr;

    rowT rows[$];
    int  cycles = 0;
    int  luTotal = 0;
    int  brTotal = 0;
    int  muTotal = 0;
    int  wtTotal = 0;

    pipeCtrl pipeCtrl_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= rows.size() + 200) begin
            $display("timeout: the run did not finish within %0d cycles", cycles);
            $display("** FAIL **");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "output mismatch");
        end
    endtask

    // ctl is {wr, load, multi, branch, cmp, iWait, dWait, eWait}.
    // stl is {stallF, stallD, flushD, stallE, flushE, stallM, flushM}.
    // fwd is {AD, BD, AE, BE}, cause is {loadUse, branch, multi, wait}.
    task automatic addRow(input logic [4:0] a1, input logic [4:0] a2, input logic [4:0] d,
                          input logic [7:0] c, input logic [6:0] s, input logic [7:0] f,
                          input logic [3:0] k);
        rows.push_back('{ra1: a1, ra2: a2, dst: d, ctl: c, stl: s, fwd: f, cause: k});
    endtask

    task automatic checkRow(input rowT r);
        checkVal("stallF", stallF, r.stl[6]);
        checkVal("stallD", stallD, r.stl[5]);
        checkVal("flushD", flushD, r.stl[4]);
        checkVal("stallE", stallE, r.stl[3]);
        checkVal("flushE", flushE, r.stl[2]);
        checkVal("stallM", stallM, r.stl[1]);
        checkVal("flushM", flushM, r.stl[0]);
        checkVal("fwdAD", fwdAD, r.fwd[7:6]);
        checkVal("fwdBD", fwdBD, r.fwd[5:4]);
        checkVal("fwdAE", fwdAE, r.fwd[3:2]);
        checkVal("fwdBE", fwdBE, r.fwd[1:0]);
    endtask

    ////////////////////////////////////////
    // APB transfers, zero wait states
    ////////////////////////////////////////

    task automatic apbWrite(input pipePkg::apbAddrT addr, input pipePkg::apbDataT data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apbRead(input pipePkg::apbAddrT addr, output pipePkg::apbDataT data,
                           output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic readCounters(input int lu, input int br, input int mu, input int wt);
        pipePkg::apbDataT rd;
        logic             err;
        apbRead(pipePkg::addrLoadUse, rd, err);
        checkVal("loadUse count", rd, lu);
        checkVal("pslverr", err, 1'b0);
        apbRead(pipePkg::addrBranch, rd, err);
        checkVal("branch count", rd, br);
        apbRead(pipePkg::addrMulti, rd, err);
        checkVal("multi count", rd, mu);
        apbRead(pipePkg::addrWait, rd, err);
        checkVal("wait count", rd, wt);
        checkVal("pslverr", err, 1'b0);
    endtask

    initial begin
        pipePkg::apbDataT rd;
        logic             err;
        rstN = 1'b0;
        {ra1, ra2, dstD} = '0;
        {wrD, loadD, multiD, branchD, branchCmpD, iWait, dWait, eWait} = '0;
        {psel, penable, pwrite, paddr, pwdata} = '0;

        // load-use on r5, then forwarding priority.
        addRow(5'd1, 5'd0, 5'd5, 8'b11000_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);
        addRow(5'd5, 5'd2, 5'd6, 8'b10000_000, 7'b1100100, 8'b00_00_00_00, 4'b1000);
        addRow(5'd5, 5'd2, 5'd6, 8'b10000_000, 7'b0000000, 8'b10_00_00_00, 4'b0000);
        addRow(5'd5, 5'd0, 5'd6, 8'b10000_000, 7'b0000000, 8'b01_00_01_00, 4'b0000);
        addRow(5'd6, 5'd0, 5'd7, 8'b10000_000, 7'b0000000, 8'b10_00_00_00, 4'b0000);
        addRow(5'd6, 5'd7, 5'd8, 8'b10000_000, 7'b0000000, 8'b10_00_10_00, 4'b0000);
        // waits.
        addRow(5'd6, 5'd7, 5'd9, 8'b10000_001, 7'b1101001, 8'b01_10_00_00, 4'b0001);
        addRow(5'd6, 5'd7, 5'd9, 8'b10000_011, 7'b1101010, 8'b00_01_00_00, 4'b0001);
        addRow(5'd6, 5'd7, 5'd9, 8'b10000_010, 7'b1101010, 8'b00_00_00_00, 4'b0001);
        addRow(5'd6, 5'd7, 5'd9, 8'b10000_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);
        // branches.
        addRow(5'd0, 5'd0, 5'd0, 8'b00010_000, 7'b0010000, 8'b00_00_00_00, 4'b0000);
        addRow(5'd8, 5'd9, 5'd10, 8'b10000_000, 7'b0000000, 8'b01_10_00_00, 4'b0000);
        addRow(5'd10, 5'd9, 5'd0, 8'b00011_000, 7'b1100100, 8'b00_01_00_01, 4'b0100);
        addRow(5'd10, 5'd9, 5'd0, 8'b00011_000, 7'b0010000, 8'b10_00_00_00, 4'b0000);
        addRow(5'd0, 5'd0, 5'd0, 8'b00010_100, 7'b1100100, 8'b00_00_01_00, 4'b0001);
        addRow(5'd0, 5'd0, 5'd0, 8'b00000_100, 7'b1010000, 8'b00_00_00_00, 4'b0001);
        // multi-cycle ops behind a load in M and a write in M.
        addRow(5'd1, 5'd0, 5'd11, 8'b11000_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);
        addRow(5'd2, 5'd3, 5'd12, 8'b10000_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);
        addRow(5'd11, 5'd0, 5'd13, 8'b10100_100, 7'b1100100, 8'b10_00_00_00, 4'b0011);
        addRow(5'd11, 5'd0, 5'd13, 8'b10100_000, 7'b0000000, 8'b01_00_00_00, 4'b0000);
        addRow(5'd0, 5'd0, 5'd14, 8'b10000_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);
        addRow(5'd13, 5'd0, 5'd15, 8'b10100_000, 7'b1100100, 8'b10_00_00_00, 4'b0010);
        addRow(5'd13, 5'd0, 5'd15, 8'b10100_000, 7'b0000000, 8'b01_00_00_00, 4'b0000);
        // load-use under iWait is not a load-use stall.
        addRow(5'd0, 5'd0, 5'd16, 8'b11000_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);
        addRow(5'd0, 5'd16, 5'd17, 8'b10000_100, 7'b1010000, 8'b00_00_00_00, 4'b0001);
        addRow(5'd0, 5'd0, 5'd0, 8'b10000_000, 7'b0000000, 8'b00_00_00_10, 4'b0000);
        // a write to r0 in E, M and W neither stalls nor forwards.
        addRow(5'd0, 5'd0, 5'd0, 8'b00001_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);
        addRow(5'd0, 5'd0, 5'd0, 8'b00000_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);
        addRow(5'd0, 5'd0, 5'd0, 8'b00000_000, 7'b0000000, 8'b00_00_00_00, 4'b0000);

        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        foreach (rows[i]) begin
            @(posedge clk);
            ra1  <= rows[i].ra1;
            ra2  <= rows[i].ra2;
            dstD <= rows[i].dst;
            {wrD, loadD, multiD, branchD, branchCmpD, iWait, dWait, eWait} <= rows[i].ctl;
            @(negedge clk);
            checkRow(rows[i]);
            luTotal += rows[i].cause[3];
            brTotal += rows[i].cause[2];
            muTotal += rows[i].cause[1];
            wtTotal += rows[i].cause[0];
        end
        @(posedge clk);
        {ra1, ra2, dstD} <= '0;
        {wrD, loadD, multiD, branchD, branchCmpD, iWait, dWait, eWait} <= '0;

        ////////////////////////////////////////
        // counter readback
        ////////////////////////////////////////

        readCounters(luTotal, brTotal, muTotal, wtTotal);
        apbWrite(pipePkg::addrClear, 32'h1, err);
        checkVal("pslverr", err, 1'b0);
        readCounters(0, 0, 0, 0);
        apbRead(8'h20, rd, err);
        checkVal("pslverr", err, 1'b1);
        apbWrite(8'h20, 32'h5, err);
        checkVal("pslverr", err, 1'b1);

        $display("** PASS **");
        $finish;
    end

endmodule

//--- files.f
common/pipePkg.sv
design/hazard/hazardUnit.sv
design/hazard/stageTracker.sv
design/perfRegs.sv
design/pipeCtrl.sv
sim/pipeCtrlTb.sv

//--- run.sh
#!/bin/sh
# build and run the pipeline control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module pipeCtrlTb -f files.f

output=$(./obj_dir/VpipeCtrlTb) || true
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
